/* design/fp_add_pkg.sv */
package fp_add_pkg;

  //////////////////////////////////////////////////////////////////////
  // Format widths and constants
  //////////////////////////////////////////////////////////////////////

  localparam int EXP_W  = 8;
  localparam int FRAC_W = 23;
  localparam int MANT_W = FRAC_W + 1;   // Hidden bit included
  localparam int EXP_MAX = 255;         // Infinity and NaN exponent

  // Guard bits kept under the mantissa while aligning
  localparam int EXT_BITS_DEF = 24;
  localparam int ALIGN_W      = MANT_W + EXT_BITS_DEF;

  localparam logic [31:0] P_INF = 32'h7F80_0000;
  localparam logic [31:0] N_INF = 32'hFF80_0000;
  localparam logic [31:0] QNAN  = 32'h7FC0_0000;

  typedef enum logic {
    FP_ADD = 1'b0,
    FP_SUB = 1'b1
  } fp_op_e;

  //////////////////////////////////////////////////////////////////////
  // Data records
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exponent;
    logic [FRAC_W-1:0] fraction;
  } float_fields_t;

  // Same word, seen as raw bits or as fields
  typedef union packed {
    logic [31:0]   bits;
    float_fields_t fields;
  } float_u;

  typedef struct packed {
    logic   is_special;   // Value below replaces the computed result
    float_u value;
    logic   invalid;
  } special_t;

  typedef struct packed {
    logic               valid;
    logic               sign;        // Sign of the larger operand
    logic [EXP_W-1:0]   exponent;
    logic               eff_sub;
    logic [ALIGN_W-1:0] mant_big;
    logic [ALIGN_W-1:0] mant_small;  // Already shifted to the big exponent
    special_t           special;
  } aligned_t;

  typedef struct packed {
    logic             valid;
    logic             sign;
    logic [EXP_W-1:0] exponent;
    logic             eff_sub;
    logic [ALIGN_W:0] sum;           // MSB is the carry
    special_t         special;
  } sum_t;

  typedef struct packed {
    logic   valid;
    float_u value;
    logic   overflow;
    logic   underflow;
    logic   invalid;
  } result_t;

endpackage

/* design/fp_align_stage.sv */
`timescale 1ns/10ps

module fp_align_stage
#(
  parameter int EXT_BITS = fp_add_pkg::EXT_BITS_DEF
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  fp_add_pkg::float_u   op_a_i,
  input  fp_add_pkg::float_u   op_b_i,
  input  fp_add_pkg::fp_op_e   op_i,
  input  logic                 valid_i,
  output fp_add_pkg::aligned_t aligned_o
);

  import fp_add_pkg::*;

  localparam int AW = MANT_W + EXT_BITS;

  float_u           b_eff;              // B after the subtract sign flip
  float_u           big_op;
  float_u           small_op;
  logic             a_is_big;
  logic [EXP_W-1:0] exp_diff;
  logic [AW-1:0]    mant_big;
  logic [AW-1:0]    mant_small;
  logic             a_nan, b_nan;
  logic             a_inf, b_inf;
  special_t         special;
  aligned_t         aligned_d;

  always_comb
  begin
    b_eff = op_b_i;
    if (op_i == FP_SUB)
      b_eff.fields.sign = ~op_b_i.fields.sign;
  end

  // Magnitude order, exponent first then fraction
  assign a_is_big = {op_a_i.fields.exponent, op_a_i.fields.fraction} >=
                    {b_eff.fields.exponent, b_eff.fields.fraction};

  assign big_op   = a_is_big ? op_a_i : b_eff;
  assign small_op = a_is_big ? b_eff : op_a_i;
  assign exp_diff = big_op.fields.exponent - small_op.fields.exponent;

  // Hidden bit is set for any nonzero exponent
  assign mant_big   = {|big_op.fields.exponent, big_op.fields.fraction, {EXT_BITS{1'b0}}};
  assign mant_small = {|small_op.fields.exponent, small_op.fields.fraction,
                       {EXT_BITS{1'b0}}} >> exp_diff;

  //////////////////////////////////////////////////////////////////////
  // Special values
  //////////////////////////////////////////////////////////////////////

  assign a_nan = (op_a_i.fields.exponent == EXP_W'(EXP_MAX)) && (|op_a_i.fields.fraction);
  assign b_nan = (b_eff.fields.exponent == EXP_W'(EXP_MAX)) && (|b_eff.fields.fraction);
  assign a_inf = op_a_i.bits[30:0] == P_INF[30:0];   // Either sign
  assign b_inf = b_eff.bits[30:0] == P_INF[30:0];

  always_comb
  begin
    special = '0;
    if (a_nan || b_nan)
    begin
      special.is_special = 1'b1;
      special.value.bits = QNAN;
      special.invalid    = 1'b1;
    end
    else if (a_inf && b_inf && (op_a_i.fields.sign != b_eff.fields.sign))
    begin
      special.is_special = 1'b1;   // inf - inf
      special.value.bits = QNAN;
      special.invalid    = 1'b1;
    end
    else if (a_inf)
    begin
      special.is_special = 1'b1;
      special.value.bits = op_a_i.fields.sign ? N_INF : P_INF;
    end
    else if (b_inf)
    begin
      special.is_special = 1'b1;
      special.value.bits = b_eff.fields.sign ? N_INF : P_INF;
    end
  end

  always_comb
  begin
    aligned_d            = '0;
    aligned_d.valid      = valid_i;
    aligned_d.sign       = big_op.fields.sign;
    aligned_d.exponent   = big_op.fields.exponent;
    aligned_d.eff_sub    = op_a_i.fields.sign ^ b_eff.fields.sign;
    aligned_d.mant_big   = mant_big;
    aligned_d.mant_small = mant_small;
    aligned_d.special    = special;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      aligned_o <= '0;
    else
      aligned_o <= aligned_d;
  end

  // Larger exponent was picked for the result
  a_big_exp : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aligned_o.valid |-> aligned_o.exponent >= $past(small_op.fields.exponent));

endmodule

/* design/fp_sum_stage.sv */
`timescale 1ns/10ps

module fp_sum_stage
#(
  parameter int EXT_BITS = fp_add_pkg::EXT_BITS_DEF
)
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  fp_add_pkg::aligned_t aligned_i,
  output fp_add_pkg::sum_t     sum_o
);

  import fp_add_pkg::*;

  localparam int AW = MANT_W + EXT_BITS;

  logic [AW-1:0] mant_big;
  logic [AW-1:0] mant_small;
  logic [AW:0]   sum_d;
  sum_t          sum_rec;

  assign mant_big   = aligned_i.mant_big;
  assign mant_small = aligned_i.mant_small;

  //////////////////////////////////////////////////////////////////////
  // Mantissa adder
  //////////////////////////////////////////////////////////////////////

  // Operands arrive ordered, so a difference is never negative
  always_comb
  begin
    if (aligned_i.eff_sub)
      sum_d = {1'b0, mant_big} - {1'b0, mant_small};
    else
      sum_d = {1'b0, mant_big} + {1'b0, mant_small};   // Carry lands in the MSB
  end

  // Everything but the mantissas is carried through
  always_comb
  begin
    sum_rec          = '0;
    sum_rec.valid    = aligned_i.valid;
    sum_rec.sign     = aligned_i.sign;
    sum_rec.exponent = aligned_i.exponent;
    sum_rec.eff_sub  = aligned_i.eff_sub;
    sum_rec.sum      = sum_d;
    sum_rec.special  = aligned_i.special;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      sum_o <= '0;
    else
      sum_o <= sum_rec;
  end

  // Holds only if the align stage ordered the operands by magnitude
  a_no_borrow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (aligned_i.valid && aligned_i.eff_sub) |=> !sum_o.sum[AW]);

endmodule

/* design/fp_normalize_stage.sv */
`timescale 1ns/10ps

module fp_normalize_stage
#(
  parameter int EXT_BITS = fp_add_pkg::EXT_BITS_DEF
)
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  fp_add_pkg::sum_t    sum_i,
  output fp_add_pkg::result_t result_o
);

  import fp_add_pkg::*;

  localparam int AW   = MANT_W + EXT_BITS;
  localparam int LZ_W = $clog2(AW + 1);

  logic              carry;
  logic [AW-1:0]     sum_mag;        // Sum without the carry bit
  logic [LZ_W-1:0]   lz_cnt;
  logic [AW-1:0]     norm_mant;
  logic [FRAC_W-1:0] norm_frac;
  logic              sum_zero;
  int                exp_calc;       // Signed, may leave the exponent range
  result_t           res_d;

  assign carry    = sum_i.sum[AW];
  assign sum_mag  = sum_i.sum[AW-1:0];
  assign sum_zero = sum_i.sum == '0;

  //////////////////////////////////////////////////////////////////////
  // Leading zero count
  //////////////////////////////////////////////////////////////////////

  // Priority encoder, highest set bit wins
  always_comb
  begin
    lz_cnt = LZ_W'(AW);
    for (int i = 0; i < AW; i++)
    begin
      if (sum_mag[i])
        lz_cnt = LZ_W'(AW - 1 - i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shift and exponent adjust
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (carry)
    begin
      norm_mant = sum_i.sum[AW:1];                  // Drop one bit, bump exponent
      exp_calc  = int'(sum_i.exponent) + 1;
    end
    else
    begin
      norm_mant = sum_mag << lz_cnt;
      exp_calc  = int'(sum_i.exponent) - int'(lz_cnt);
    end
  end

  // Truncate below the hidden bit
  assign norm_frac = norm_mant[AW-2 -: FRAC_W];

  //////////////////////////////////////////////////////////////////////
  // Result select and flags
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    res_d       = '0;
    res_d.valid = sum_i.valid;
    if (sum_i.special.is_special)
    begin
      res_d.value   = sum_i.special.value;
      res_d.invalid = sum_i.special.invalid;
    end
    else if (sum_zero)
    begin
      res_d.value.bits = '0;                        // Exact cancellation gives +0
    end
    else if (exp_calc >= EXP_MAX)
    begin
      res_d.value.bits = sum_i.sign ? N_INF : P_INF;
      res_d.overflow   = 1'b1;
    end
    else if (exp_calc < 1)
    begin
      res_d.value.fields.sign = sum_i.sign;         // Signed zero
      res_d.underflow         = 1'b1;
    end
    else
    begin
      res_d.value.fields.sign     = sum_i.sign;
      res_d.value.fields.exponent = exp_calc[EXP_W-1:0];
      res_d.value.fields.fraction = norm_frac;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      result_o <= '0;
    else
      result_o <= res_d;
  end

  // Invalid comes from the align stage, the range flags from here
  a_one_flag : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sum_i.valid |=> $onehot0({result_o.overflow, result_o.underflow, result_o.invalid}));

endmodule

/* design/fp_add_unit.sv */
`timescale 1ns/10ps

module fp_add_unit
#(
  parameter int EXT_BITS = fp_add_pkg::EXT_BITS_DEF
)
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  fp_add_pkg::float_u  op_a_i,
  input  fp_add_pkg::float_u  op_b_i,
  input  fp_add_pkg::fp_op_e  op_i,
  input  logic                valid_i,
  output fp_add_pkg::result_t result_o
);

  import fp_add_pkg::*;

  aligned_t aligned;   // Align to sum
  sum_t     summed;    // Sum to normalize

  // Stage records are sized by the package default
  if (MANT_W + EXT_BITS != ALIGN_W)
  begin : g_ext_check
    $error("EXT_BITS does not match the stage record width");
  end

  //////////////////////////////////////////////////////////////////////
  // Three-stage pipeline
  //////////////////////////////////////////////////////////////////////

  fp_align_stage #(
    .EXT_BITS (EXT_BITS)
  ) align0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .op_a_i    (op_a_i),
    .op_b_i    (op_b_i),
    .op_i      (op_i),
    .valid_i   (valid_i),
    .aligned_o (aligned)
  );

  fp_sum_stage #(
    .EXT_BITS (EXT_BITS)
  ) sum0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .aligned_i (aligned),
    .sum_o     (summed)
  );

  fp_normalize_stage #(
    .EXT_BITS (EXT_BITS)
  ) norm0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sum_i    (summed),
    .result_o (result_o)
  );

endmodule

/* dv/fp_add_checks.svh */
`ifndef FP_ADD_CHECKS_SVH
`define FP_ADD_CHECKS_SVH

// Whole result word compared bit for bit
task automatic check_value(input float_u got, input float_u want, input int case_idx);
  if (got.bits !== want.bits)
  begin
    $display("[FAIL] %t case %0d: value %h (sign %b exp %h frac %h), expected %h",
             $realtime, case_idx, got.bits, got.fields.sign, got.fields.exponent,
             got.fields.fraction, want.bits);
    abort_run();
  end
endtask

// Overflow, underflow and invalid as one group
task automatic check_flags(input result_t got, input result_t want, input int case_idx);
  logic [2:0] got_f;
  logic [2:0] want_f;
  got_f  = {got.overflow, got.underflow, got.invalid};
  want_f = {want.overflow, want.underflow, want.invalid};
  if (got_f !== want_f)
  begin
    $display("[FAIL] %t case %0d: flags ovf/unf/inv %b, expected %b",
             $realtime, case_idx, got_f, want_f);
    abort_run();
  end
endtask

// Cycles from the driven valid_i to the output strobe
task automatic check_latency(input int got, input int want, input int case_idx);
  if (got != want)
  begin
    $display("[FAIL] %t case %0d: latency %0d cycles, expected %0d",
             $realtime, case_idx, got, want);
    abort_run();
  end
endtask

`endif

/* dv/fp_add_unit_tb.sv */
`timescale 1ns/10ps

module fp_add_unit_tb;

  import fp_add_pkg::*;

  localparam int EXT_BITS   = 24;
  localparam int MAX_CASES  = 64;
  localparam int CASE_WORDS = 6;    // a, b, op, gap, result, flags
  localparam int LATENCY    = 3;
  localparam int TIMEOUT    = 20;

  logic    clk_i;
  logic    rst_n_i;
  float_u  op_a_i;
  float_u  op_b_i;
  fp_op_e  op_i;
  logic    valid_i;
  result_t result_o;

  logic [31:0] case_mem [0:MAX_CASES*CASE_WORDS-1];
  result_t     exp_q[$];            // Expected results in issue order
  int          issue_q[$];
  int          case_q[$];
  int          cycle_cnt = 0;
  integer      seed;

  fp_add_unit #(
    .EXT_BITS (EXT_BITS)
  ) dut0 (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .op_i     (op_i),
    .valid_i  (valid_i),
    .result_o (result_o)
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "fp_add_checks.svh"

  initial
  begin
    clk_i = 1'b0;
    forever
      #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////////////////////////////////////////////
  // Driver
  //////////////////////////////////////////////////////////////////////

  task automatic drive_idle(input int cycles);
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk_i);
      valid_i = 1'b0;
    end
  endtask

  task automatic drive_op(input float_u a, input float_u b, input fp_op_e op,
                          input result_t want, input int case_idx);
    @(negedge clk_i);
    op_a_i  = a;
    op_b_i  = b;
    op_i    = op;
    valid_i = 1'b1;
    exp_q.push_back(want);
    issue_q.push_back(cycle_cnt);   // Cycle in which valid_i is presented
    case_q.push_back(case_idx);
  endtask

  task automatic finish_run();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < TIMEOUT)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0)
    begin
      $display("No result arrived within %0d cycles for %0d pending operations",
               TIMEOUT, exp_q.size());
      abort_run();
    end
    else
    begin
      drive_idle(LATENCY + 1);      // Any late pulse here is an extra one
      $display("TEST OK");
      $finish;
    end
  endtask

  initial
  begin
    int      base;
    int      gap;
    logic    found_end;
    result_t want;
    $timeformat(-9, 1, " ns", 0);
    seed    = 80;
    rst_n_i = 1'b0;
    op_a_i  = '0;
    op_b_i  = '0;
    op_i    = FP_ADD;
    valid_i = 1'b0;
    $readmemh("dv/fp_add_cases.txt", case_mem);
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    drive_idle(LATENCY);            // Monitor flags any strobe from the empty pipeline
    found_end = 1'b0;
    for (int idx = 0; idx < MAX_CASES && !found_end; idx++)
    begin
      base = idx * CASE_WORDS;
      if (case_mem[base + 2] == 32'hE)
        found_end = 1'b1;
      else
      begin
        gap = case_mem[base + 3];
        if (gap == 'hF)
          gap = $random(seed) & 3;
        drive_idle(gap);
        want            = '0;
        want.valid      = 1'b1;
        want.value.bits = case_mem[base + 4];
        want.overflow   = case_mem[base + 5][2];
        want.underflow  = case_mem[base + 5][1];
        want.invalid    = case_mem[base + 5][0];
        drive_op(case_mem[base], case_mem[base + 1], fp_op_e'(case_mem[base + 2][0]),
                 want, idx + 1);
      end
    end
    if (!found_end)
    begin
      $display("Case file has no end marker line");
      abort_run();
    end
    else
    begin
      drive_idle(1);
      finish_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i)
  begin : monitor_blk
    result_t want;
    int      case_idx;
    if (rst_n_i)
    begin
      if (result_o.valid)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Valid result at %t with no operation pending", $realtime);
          abort_run();
        end
        else
        begin
          want     = exp_q.pop_front();
          case_idx = case_q.pop_front();
          check_latency(cycle_cnt - issue_q.pop_front(), LATENCY, case_idx);
          check_value(result_o.value, want.value, case_idx);
          check_flags(result_o, want, case_idx);
        end
      end
      else if (exp_q.size() != 0 && cycle_cnt - issue_q[0] > TIMEOUT)
      begin
        $display("No result arrived within %0d cycles for case %0d", TIMEOUT, case_q[0]);
        abort_run();
      end
    end
  end

endmodule

/* dv/fp_add_cases.txt */
// a        b        op gap result   flags (op 0 add, 1 sub, E ends the list; gap F is random)
// flags digit is overflow*4 + underflow*2 + invalid
3F800000 3F800000 0 1 40000000 0
3F800000 40000000 0 0 40400000 0
3FC00000 3FC00000 0 0 40400000 0
40400000 3F800000 0 0 40800000 0
3F800000 3F000000 0 2 3FC00000 0
00000000 00000000 0 0 00000000 0
00000000 3F800000 0 0 3F800000 0
4B800000 3F800000 0 0 4B800000 0
3F800000 0D800000 0 0 3F800000 0
3F800001 3F800000 0 F 40000000 0
3F800001 3F800001 0 0 40000001 0
40400000 3F800000 1 2 40000000 0
3F800000 3F800000 1 0 00000000 0
BF800000 3F800000 0 0 00000000 0
3F800000 3F000000 1 F 3F000000 0
40000000 40400000 1 0 BF800000 0
3F800001 3F800000 1 0 34000000 0
C0400000 3F800000 0 F C0000000 0
40000000 33800000 1 0 3FFFFFFF 0
40A00000 BFC00000 0 0 40600000 0
00000000 00000000 1 1 00000000 0
7FC00000 3F800000 0 0 7FC00000 1
3F800000 7F800001 1 0 7FC00000 1
7F800000 7F800000 1 F 7FC00000 1
7F800000 FF800000 0 0 7FC00000 1
7F800000 7F800000 0 0 7F800000 0
7F800000 3F800000 0 0 7F800000 0
3F800000 7F800000 1 F FF800000 0
FF800000 40A00000 0 0 FF800000 0
FF800000 FF800000 1 0 7FC00000 1
7F7FFFFF 7F7FFFFF 0 2 7F800000 4
7F000000 FF000000 1 F 7F800000 4
7F000000 7E800000 0 0 7F400000 0
01000001 01000000 1 0 00000000 2
01000000 01000001 1 F 80000000 2
01000000 00800000 1 0 00800000 0
00000000 00000000 E 0 00000000 0

/* sources.f */
+incdir+dv
design/fp_add_pkg.sv
design/fp_align_stage.sv
design/fp_sum_stage.sv
design/fp_normalize_stage.sv
design/fp_add_unit.sv
dv/fp_add_unit_tb.sv

/* Makefile */
TOP := fp_add_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
